// File: design/uart_string_pkg.sv
// uart string link shared definitions
// widths, serial timing, frame marker and the frame state encodings

package uart_string_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// string sizing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int MAX_LEN = 16;

	typedef logic [7:0] byte_t;
	// length 0..MAX_LEN
	typedef logic [4:0] len_t;
	// byte 0 sits in bits 7:0
	typedef logic [8*MAX_LEN-1:0] str_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// serial timing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// 100 MHz sys_clk at 6.25 Mbaud
	localparam int CLKS_PER_BIT = 16;
	localparam int BIT_CNT_W = $clog2(CLKS_PER_BIT);
	localparam int TX_STOP_BITS = 2;

	typedef logic [BIT_CNT_W-1:0] baud_cnt_t;
	// data bit or stop bit position
	typedef logic [2:0] bit_idx_t;

	// ascii '&'
	localparam byte_t FRAME_MARK = 8'h26;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame state machines
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_MARK1,
		TX_MARK2,
		TX_CONTENT,
		TX_MARK3,
		TX_MARK4,
		TX_FINISH
	} tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_MARK1,
		RX_CONTENT,
		RX_MARK_SEEN,
		RX_CLOSING,
		RX_FINISH
	} rx_state_e;

endpackage

// File: design/uart_tx.sv
// uart byte transmitter
// start bit, 8 data bits lsb first, TX_STOP_BITS stop bits
// byte_done pulses once at the end of the last stop bit

`timescale 1ns/10ps

module uart_tx (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  uart_string_pkg::byte_t  byte_data,
	input  logic                    byte_req,
	output logic                    tx,
	output logic                    byte_done
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP
	} tx_bit_e;

	tx_bit_e                    state;
	uart_string_pkg::baud_cnt_t baud_cnt;
	uart_string_pkg::bit_idx_t  bit_idx;
	uart_string_pkg::byte_t     data_q;
	logic                       bit_end;

	// last cycle of the current bit period
	assign bit_end = (baud_cnt == uart_string_pkg::baud_cnt_t'(uart_string_pkg::CLKS_PER_BIT - 1));

	// byte latched when a request is taken
	always_ff @(posedge sys_clk) begin
		if (state == S_IDLE && byte_req) begin
			data_q <= byte_data;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= S_IDLE;
			baud_cnt  <= '0;
			bit_idx   <= '0;
			tx        <= 1'b1;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			case (state)
				S_IDLE: begin
					tx       <= 1'b1;
					baud_cnt <= '0;
					if (byte_req) begin
						state <= S_START;
						tx    <= 1'b0;
					end
				end
				S_START: begin
					baud_cnt <= baud_cnt + 1'b1;
					if (bit_end) begin
						state   <= S_DATA;
						bit_idx <= '0;
						tx      <= data_q[0];
					end
				end
				S_DATA: begin
					baud_cnt <= baud_cnt + 1'b1;
					if (bit_end) begin
						if (bit_idx == 3'd7) begin
							// first stop bit
							state   <= S_STOP;
							bit_idx <= '0;
							tx      <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							tx      <= data_q[bit_idx + 1'b1];
						end
					end
				end
				S_STOP: begin
					baud_cnt <= baud_cnt + 1'b1;
					if (bit_end) begin
						if (bit_idx == uart_string_pkg::bit_idx_t'(uart_string_pkg::TX_STOP_BITS - 1)) begin
							state     <= S_IDLE;
							byte_done <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: design/uart_rx.sv
// uart byte receiver
// two-flop input sync, start bit checked at its middle, data sampled mid-bit
// rx_vld pulses in the middle of a stop bit that reads high

`timescale 1ns/10ps

module uart_rx (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    rx,
	output uart_string_pkg::byte_t  rx_byte,
	output logic                    rx_vld
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP
	} rx_bit_e;

	rx_bit_e                    state;
	logic                       rx_s1;
	logic                       rx_s2;
	logic                       rx_s3;
	logic                       fall;
	uart_string_pkg::baud_cnt_t baud_cnt;
	uart_string_pkg::bit_idx_t  bit_idx;
	uart_string_pkg::byte_t     shift_q;
	logic                       half_end;
	logic                       bit_end;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// line sync and edge detect
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
			rx_s3 <= 1'b1;
		end else begin
			rx_s1 <= rx;
			rx_s2 <= rx_s1;
			rx_s3 <= rx_s2;
		end
	end

	assign fall     = rx_s3 & ~rx_s2;
	assign half_end = (baud_cnt == uart_string_pkg::baud_cnt_t'(uart_string_pkg::CLKS_PER_BIT / 2 - 1));
	assign bit_end  = (baud_cnt == uart_string_pkg::baud_cnt_t'(uart_string_pkg::CLKS_PER_BIT - 1));

	// bits arrive lsb first, so shift in at the top
	always_ff @(posedge sys_clk) begin
		if (state == S_DATA && bit_end) begin
			shift_q <= {rx_s2, shift_q[7:1]};
		end
	end

	assign rx_byte = shift_q;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bit state machine
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= S_IDLE;
			baud_cnt <= '0;
			bit_idx  <= '0;
			rx_vld   <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			case (state)
				S_IDLE: begin
					baud_cnt <= '0;
					if (fall) begin
						state <= S_START;
					end
				end
				S_START: begin
					baud_cnt <= baud_cnt + 1'b1;
					if (half_end) begin
						// glitch if the line is back high
						baud_cnt <= '0;
						bit_idx  <= '0;
						state    <= rx_s2 ? S_IDLE : S_DATA;
					end
				end
				S_DATA: begin
					baud_cnt <= baud_cnt + 1'b1;
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= S_STOP;
						end
					end
				end
				S_STOP: begin
					baud_cnt <= baud_cnt + 1'b1;
					if (bit_end) begin
						state  <= S_IDLE;
						// framing error drops the byte
						rx_vld <= rx_s2;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// File: design/uart_string_handle.sv
// uart string link top
// sends a host string as && content && and deframes incoming strings
// drives one byte transmitter and one byte receiver

`timescale 1ns/10ps

module uart_string_handle (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  uart_string_pkg::str_t   tx_string,
	input  uart_string_pkg::len_t   tx_length,
	input  logic                    tx_req,
	output logic                    tx_busy,
	output logic                    tx_done,
	output uart_string_pkg::str_t   rx_string,
	output uart_string_pkg::len_t   rx_length,
	output logic                    rx_busy,
	output logic                    rx_done,
	input  logic                    uart_rx_port,
	output logic                    uart_tx_port
);

	uart_string_pkg::tx_state_e tx_state;
	uart_string_pkg::tx_state_e tx_state_nxt;
	uart_string_pkg::str_t      tx_buf;
	uart_string_pkg::len_t      tx_len_q;
	uart_string_pkg::len_t      tx_cnt;
	logic                       tx_accept;
	logic                       send_mark;
	logic                       send_char;

	uart_string_pkg::byte_t     byte_data;
	logic                       byte_req;
	logic                       byte_done;

	uart_string_pkg::rx_state_e rx_state;
	uart_string_pkg::rx_state_e rx_state_nxt;
	uart_string_pkg::byte_t     rx_byte;
	logic                       rx_vld;
	logic                       is_mark;
	logic                       is_char;
	logic                       wr_one;
	logic                       wr_two;
	logic                       rx_fresh;
	uart_string_pkg::len_t      cur_len;
	uart_string_pkg::len_t      sum_len;
	uart_string_pkg::byte_t     first_byte;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// transmit side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign tx_accept = (tx_state == uart_string_pkg::TX_IDLE) && tx_req
		&& (tx_length != '0)
		&& (tx_length <= uart_string_pkg::len_t'(uart_string_pkg::MAX_LEN));

	// which byte goes out next
	assign send_mark = tx_accept || (byte_done && (
		(tx_state == uart_string_pkg::TX_MARK1) ||
		(tx_state == uart_string_pkg::TX_MARK3) ||
		(tx_state == uart_string_pkg::TX_CONTENT && tx_cnt == tx_len_q)));
	assign send_char = byte_done && (
		(tx_state == uart_string_pkg::TX_MARK2) ||
		(tx_state == uart_string_pkg::TX_CONTENT && tx_cnt != tx_len_q));

	always_comb begin
		tx_state_nxt = tx_state;
		case (tx_state)
			uart_string_pkg::TX_IDLE:
				if (tx_accept) tx_state_nxt = uart_string_pkg::TX_MARK1;
			uart_string_pkg::TX_MARK1:
				if (byte_done) tx_state_nxt = uart_string_pkg::TX_MARK2;
			uart_string_pkg::TX_MARK2:
				if (byte_done) tx_state_nxt = uart_string_pkg::TX_CONTENT;
			uart_string_pkg::TX_CONTENT:
				if (byte_done && tx_cnt == tx_len_q) tx_state_nxt = uart_string_pkg::TX_MARK3;
			uart_string_pkg::TX_MARK3:
				if (byte_done) tx_state_nxt = uart_string_pkg::TX_MARK4;
			uart_string_pkg::TX_MARK4:
				if (byte_done) tx_state_nxt = uart_string_pkg::TX_FINISH;
			default:
				tx_state_nxt = uart_string_pkg::TX_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state <= uart_string_pkg::TX_IDLE;
			tx_cnt   <= '0;
			byte_req <= 1'b0;
		end else begin
			tx_state <= tx_state_nxt;
			byte_req <= send_mark | send_char;
			if (tx_accept) begin
				tx_cnt <= '0;
			end else if (send_char) begin
				tx_cnt <= tx_cnt + 1'b1;
			end
		end
	end

	// string is shifted down one byte per content byte sent
	always_ff @(posedge sys_clk) begin
		if (tx_accept) begin
			tx_buf   <= tx_string;
			tx_len_q <= tx_length;
		end
		if (send_mark) begin
			byte_data <= uart_string_pkg::FRAME_MARK;
		end else if (send_char) begin
			byte_data <= tx_buf[7:0];
			tx_buf    <= tx_buf >> 8;
		end
	end

	assign tx_busy = (tx_state != uart_string_pkg::TX_IDLE);
	assign tx_done = (tx_state == uart_string_pkg::TX_FINISH);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// receive side
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign is_mark = rx_vld && (rx_byte == uart_string_pkg::FRAME_MARK);
	assign is_char = rx_vld && (rx_byte != uart_string_pkg::FRAME_MARK);
	assign wr_one  = is_char && (rx_state == uart_string_pkg::RX_CONTENT);
	// a lone mark inside content is kept along with the byte after it
	assign wr_two  = is_char && (rx_state == uart_string_pkg::RX_MARK_SEEN);

	// length restarts on the opening pair but rx_length holds until the first byte
	assign cur_len    = rx_fresh ? '0 : rx_length;
	assign sum_len    = cur_len + (wr_two ? 5'd2 : 5'd1);
	assign first_byte = wr_two ? uart_string_pkg::FRAME_MARK : rx_byte;

	always_comb begin
		rx_state_nxt = rx_state;
		case (rx_state)
			uart_string_pkg::RX_IDLE:
				if (is_mark) rx_state_nxt = uart_string_pkg::RX_MARK1;
			uart_string_pkg::RX_MARK1:
				if (is_mark) rx_state_nxt = uart_string_pkg::RX_CONTENT;
				else if (is_char) rx_state_nxt = uart_string_pkg::RX_IDLE;
			uart_string_pkg::RX_CONTENT:
				if (is_mark) rx_state_nxt = uart_string_pkg::RX_MARK_SEEN;
			uart_string_pkg::RX_MARK_SEEN:
				if (is_mark) rx_state_nxt = uart_string_pkg::RX_CLOSING;
				else if (is_char) rx_state_nxt = uart_string_pkg::RX_CONTENT;
			uart_string_pkg::RX_CLOSING:
				rx_state_nxt = uart_string_pkg::RX_FINISH;
			default:
				rx_state_nxt = uart_string_pkg::RX_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state  <= uart_string_pkg::RX_IDLE;
			rx_length <= '0;
			rx_fresh  <= 1'b0;
		end else begin
			rx_state <= rx_state_nxt;
			if (rx_state == uart_string_pkg::RX_MARK1 && is_mark) begin
				rx_fresh <= 1'b1;
			end else if (wr_one || wr_two) begin
				rx_fresh <= 1'b0;
				// clip at MAX_LEN
				if (sum_len > uart_string_pkg::len_t'(uart_string_pkg::MAX_LEN)) begin
					rx_length <= uart_string_pkg::len_t'(uart_string_pkg::MAX_LEN);
				end else begin
					rx_length <= sum_len;
				end
			end else if (rx_state == uart_string_pkg::RX_CLOSING) begin
				// empty frame commits length 0 here
				rx_fresh  <= 1'b0;
				rx_length <= cur_len;
			end
		end
	end

	// slots past MAX_LEN never match, which drops overflow bytes
	always_ff @(posedge sys_clk) begin
		for (int i = 0; i < uart_string_pkg::MAX_LEN; i++) begin
			if ((wr_one || wr_two) && cur_len == i) begin
				rx_string[8*i +: 8] <= first_byte;
			end else if (wr_two && (cur_len + 5'd1) == i) begin
				rx_string[8*i +: 8] <= rx_byte;
			end
		end
	end

	assign rx_busy = (rx_state != uart_string_pkg::RX_IDLE);
	assign rx_done = (rx_state == uart_string_pkg::RX_FINISH);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// byte level uart
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.tx        (uart_tx_port),
		.byte_done (byte_done)
	);

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx        (uart_rx_port),
		.rx_byte   (rx_byte),
		.rx_vld    (rx_vld)
	);

endmodule

// File: testbench/tb_uart_string_checker.sv
// uart string link checker
// decodes both serial lines, models framing and deframing,
// compares the DUT outputs against the model and counts errors

`timescale 1ns/10ps

module tb_uart_string_checker (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  uart_string_pkg::str_t tx_string,
	input  uart_string_pkg::len_t tx_length,
	input  logic                  tx_req,
	input  logic                  tx_busy,
	input  logic                  tx_done,
	input  uart_string_pkg::str_t rx_string,
	input  uart_string_pkg::len_t rx_length,
	input  logic                  rx_busy,
	input  logic                  rx_done,
	input  logic                  uart_rx_port,
	input  logic                  uart_tx_port,
	input  logic [8*16-1:0]       test_name,
	output int                    err_count,
	output int                    tx_frames,
	output int                    rx_frames
);

	localparam int HALF = uart_string_pkg::CLKS_PER_BIT / 2;
	localparam uart_string_pkg::byte_t MARK = uart_string_pkg::FRAME_MARK;

	// deframing model states
	localparam int M_IDLE    = 0;
	localparam int M_MARK1   = 1;
	localparam int M_CONTENT = 2;
	localparam int M_SEEN    = 3;

	uart_string_pkg::byte_t tx_exp_q[$];
	int                     exp_len_q[$];
	uart_string_pkg::str_t  exp_str_q[$];
	// index 0 watches the tx line, index 1 the rx line
	int                     pos[2];
	uart_string_pkg::byte_t shreg[2];
	int                     tx_open;
	bit                     busy_chk;
	bit                     rst_checked;
	int                     m_state;
	int                     m_len;
	uart_string_pkg::str_t  m_str;

	task automatic flag_mismatch(input string what, input logic [127:0] exp_v,
		input logic [127:0] act_v);
		$display("CHECK FAILED %0s %0s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
		err_count++;
	endtask

	task automatic flag_problem(input string msg);
		$display("ERROR in %0s: %0s", test_name, msg);
		err_count++;
	endtask

	// one clock step of a mid-bit sampling line decoder
	task automatic sample_line(input int k, input logic v, output bit got,
		output uart_string_pkg::byte_t b);
		int idx;
		got = 1'b0;
		b = shreg[k];
		if (pos[k] == 0) begin
			if (v == 1'b0) pos[k] = 1;
		end else begin
			pos[k]++;
			if (pos[k] >= HALF && (pos[k] - HALF) % uart_string_pkg::CLKS_PER_BIT == 0) begin
				idx = (pos[k] - HALF) / uart_string_pkg::CLKS_PER_BIT;
				if (idx == 0 && v) begin
					pos[k] = 0;
				end else if (idx >= 1 && idx <= 8) begin
					shreg[k] = {v, shreg[k][7:1]};
				end else if (idx == 9) begin
					pos[k] = 0;
					b = shreg[k];
					got = v;
					if (!v) flag_problem($sformatf("stop bit low on serial line %0d", k));
				end
			end
		end
	endtask

	task automatic store_byte(input uart_string_pkg::byte_t b);
		if (m_len < uart_string_pkg::MAX_LEN) begin
			m_str[8*m_len +: 8] = b;
			m_len++;
		end
	endtask

	task automatic deframe(input uart_string_pkg::byte_t b);
		case (m_state)
			M_IDLE: begin
				if (b == MARK) m_state = M_MARK1;
			end
			M_MARK1: begin
				if (b == MARK) begin
					m_state = M_CONTENT;
					m_len = 0;
					m_str = '0;
				end else begin
					m_state = M_IDLE;
				end
			end
			M_CONTENT: begin
				if (b == MARK) m_state = M_SEEN;
				else store_byte(b);
			end
			default: begin
				if (b == MARK) begin
					exp_len_q.push_back(m_len);
					exp_str_q.push_back(m_str);
					m_state = M_IDLE;
				end else begin
					store_byte(MARK);
					store_byte(b);
					m_state = M_CONTENT;
				end
			end
		endcase
	endtask

	always @(posedge sys_clk) begin : monitor
		bit                     got;
		uart_string_pkg::byte_t b;
		uart_string_pkg::byte_t exp_b;
		int                     exp_len;
		uart_string_pkg::str_t  exp_str;
		uart_string_pkg::str_t  mask;
		if (!sys_rst_n) begin
			err_count = 0;
			tx_frames = 0;
			rx_frames = 0;
			pos[0] = 0;
			pos[1] = 0;
			tx_open = 0;
			busy_chk = 1'b0;
			rst_checked = 1'b0;
			m_state = M_IDLE;
			m_len = 0;
			tx_exp_q.delete();
			exp_len_q.delete();
			exp_str_q.delete();
		end else begin
			if (!rst_checked) begin
				rst_checked = 1'b1;
				if ({uart_tx_port, tx_busy, tx_done, rx_busy, rx_done} != 5'b10000) begin
					flag_mismatch("reset outputs", 5'b10000,
						{uart_tx_port, tx_busy, tx_done, rx_busy, rx_done});
				end
				if (rx_length != '0) begin
					flag_mismatch("reset rx_length", 0, rx_length);
				end
			end

			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// transmit model
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			if (tx_req && !tx_busy && tx_length >= 1 && tx_length <= uart_string_pkg::MAX_LEN) begin
				tx_exp_q.push_back(MARK);
				tx_exp_q.push_back(MARK);
				for (int i = 0; i < int'(tx_length); i++) begin
					tx_exp_q.push_back(tx_string[8*i +: 8]);
				end
				tx_exp_q.push_back(MARK);
				tx_exp_q.push_back(MARK);
				tx_open++;
			end
			if (busy_chk && tx_busy) flag_problem("tx_busy still high after tx_done");
			busy_chk = 1'b0;
			if (tx_done) begin
				tx_frames++;
				busy_chk = 1'b1;
				if (tx_open == 0) flag_problem("tx_done without an accepted request");
				else tx_open--;
				if (tx_exp_q.size() != 0) flag_mismatch("bytes left at tx_done", 0, tx_exp_q.size());
			end
			sample_line(0, uart_tx_port, got, b);
			if (got) begin
				if (tx_exp_q.size() == 0) begin
					flag_problem($sformatf("unexpected byte %02h on the tx line", b));
				end else begin
					exp_b = tx_exp_q.pop_front();
					if (b != exp_b) flag_mismatch("tx line byte", exp_b, b);
				end
			end

			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			// receive model
			// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
			sample_line(1, uart_rx_port, got, b);
			if (got) deframe(b);
			// opening pair already on the line, so the receive FSM is out of idle
			if ((m_state == M_CONTENT || m_state == M_SEEN) && !rx_busy) begin
				flag_problem("rx_busy low inside a frame");
			end
			if (rx_done) begin
				rx_frames++;
				if (exp_len_q.size() == 0) begin
					flag_problem("rx_done without a closed frame on the rx line");
				end else begin
					exp_len = exp_len_q.pop_front();
					exp_str = exp_str_q.pop_front();
					mask = '0;
					for (int i = 0; i < exp_len; i++) mask[8*i +: 8] = 8'hff;
					if (int'(rx_length) != exp_len) flag_mismatch("rx_length", exp_len, rx_length);
					if ((rx_string & mask) != (exp_str & mask)) begin
						flag_mismatch("rx_string", exp_str & mask, rx_string & mask);
					end
				end
			end
		end
	end

endmodule

// File: testbench/tb_uart_string.sv
// uart string link testbench
// random strings through the transmitter, loopback, and driven frames
// for lone marks, noise, overflow and ignored requests

`timescale 1ns/10ps

module tb_uart_string;

	localparam int TX_STRINGS    = 20;
	localparam int LOOP_STRINGS  = 5;
	localparam int MARK_FRAMES   = 3;
	localparam int FRAME_TIMEOUT = 8000;
	localparam int SEED          = 32'h73b3_2d32;
	// about three frame bytes on the line
	localparam int QUIET_CYCLES  = 33 * uart_string_pkg::CLKS_PER_BIT;

	logic                   sys_clk;
	logic                   sys_rst_n;
	uart_string_pkg::str_t  tx_string;
	uart_string_pkg::len_t  tx_length;
	logic                   tx_req;
	logic                   tx_busy;
	logic                   tx_done;
	uart_string_pkg::str_t  rx_string;
	uart_string_pkg::len_t  rx_length;
	logic                   rx_busy;
	logic                   rx_done;
	logic                   uart_rx_port;
	logic                   uart_tx_port;
	logic                   loop_sel;
	logic                   drv_line;
	logic [8*16-1:0]        test_name;
	int                     err_count;
	int                     tx_frames;
	int                     rx_frames;
	int                     timeouts;
	int                     tx_sent;
	int                     rx_expect;
	int                     mark_pos;
	int                     n_chars;
	uart_string_pkg::byte_t line_q[$];

	always #5 sys_clk = ~sys_clk;

	assign uart_rx_port = loop_sel ? uart_tx_port : drv_line;

	uart_string_handle u_uart_string_handle (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	tb_uart_string_checker u_checker (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port),
		.test_name    (test_name),
		.err_count    (err_count),
		.tx_frames    (tx_frames),
		.rx_frames    (rx_frames)
	);

	// any byte except the frame mark
	function automatic uart_string_pkg::byte_t rand_char();
		uart_string_pkg::byte_t b;
		b = uart_string_pkg::byte_t'($urandom);
		if (b == uart_string_pkg::FRAME_MARK) b = ~b;
		return b;
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge sys_clk);
		#1;
	endtask

	task automatic pulse_req(input int len);
		@(posedge sys_clk);
		#1;
		tx_length = uart_string_pkg::len_t'(len);
		tx_req = 1'b1;
		@(posedge sys_clk);
		#1;
		tx_req = 1'b0;
	endtask

	// random content, unused bytes random too
	task automatic send_string(input int len);
		tx_string = {$urandom, $urandom, $urandom, $urandom};
		for (int i = 0; i < len; i++) tx_string[8*i +: 8] = rand_char();
		pulse_req(len);
	endtask

	task automatic wait_frames(input int tx_target, input int rx_target);
		int cycles;
		cycles = 0;
		while ((tx_frames < tx_target || rx_frames < rx_target) && cycles < FRAME_TIMEOUT) begin
			@(posedge sys_clk);
			#1;
			cycles++;
		end
		if (tx_frames < tx_target || rx_frames < rx_target) begin
			$display("timeout in %0s: no tx_done or rx_done after %0d cycles", test_name, cycles);
			timeouts++;
		end
	endtask

	// start bit, data lsb first, two stop bits
	task automatic drive_byte(input uart_string_pkg::byte_t b);
		logic [10:0] bits;
		bits = {2'b11, b, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge sys_clk);
			#1;
			drv_line = bits[i];
			repeat (uart_string_pkg::CLKS_PER_BIT - 1) @(posedge sys_clk);
		end
	endtask

	task automatic drive_queue();
		while (line_q.size() > 0) drive_byte(line_q.pop_front());
	endtask

	task automatic push_marks();
		line_q.push_back(uart_string_pkg::FRAME_MARK);
		line_q.push_back(uart_string_pkg::FRAME_MARK);
	endtask

	initial begin
		sys_clk = 1'b0;
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req = 1'b0;
		loop_sel = 1'b0;
		drv_line = 1'b1;
		timeouts = 0;
		tx_sent = 0;
		rx_expect = 0;
		test_name = "reset";
		void'($urandom(SEED));
		repeat (4) @(posedge sys_clk);
		#1;
		sys_rst_n = 1'b1;
		idle_cycles(4);

		test_name = "tx_framing";
		for (int n = 0; n < TX_STRINGS; n++) begin
			send_string($urandom_range(uart_string_pkg::MAX_LEN, 1));
			tx_sent++;
			wait_frames(tx_sent, rx_expect);
		end

		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		// loopback, switched only while both lines idle
		// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
		test_name = "loopback";
		loop_sel = 1'b1;
		for (int n = 0; n < LOOP_STRINGS; n++) begin
			send_string($urandom_range(uart_string_pkg::MAX_LEN, 1));
			tx_sent++;
			rx_expect++;
			wait_frames(tx_sent, rx_expect);
		end
		idle_cycles(2 * uart_string_pkg::CLKS_PER_BIT);
		loop_sel = 1'b0;

		test_name = "single_mark";
		for (int n = 0; n < MARK_FRAMES; n++) begin
			n_chars = $urandom_range(6, 2);
			mark_pos = $urandom_range(n_chars - 1, 0);
			push_marks();
			for (int i = 0; i < n_chars; i++) begin
				if (i == mark_pos) line_q.push_back(uart_string_pkg::FRAME_MARK);
				line_q.push_back(rand_char());
			end
			push_marks();
			drive_queue();
			rx_expect++;
			wait_frames(tx_sent, rx_expect);
		end

		// junk, then a lone mark in idle, then a short frame
		test_name = "noise_restart";
		repeat (3) line_q.push_back(rand_char());
		line_q.push_back(uart_string_pkg::FRAME_MARK);
		line_q.push_back(rand_char());
		push_marks();
		repeat ($urandom_range(5, 1)) line_q.push_back(rand_char());
		push_marks();
		drive_queue();
		rx_expect++;
		wait_frames(tx_sent, rx_expect);

		test_name = "overflow";
		push_marks();
		repeat (20) line_q.push_back(rand_char());
		push_marks();
		drive_queue();
		rx_expect++;
		wait_frames(tx_sent, rx_expect);

		test_name = "ignored_req";
		pulse_req(0);
		pulse_req(uart_string_pkg::MAX_LEN + 1);
		idle_cycles(QUIET_CYCLES);
		send_string(3);
		tx_sent++;
		// second request lands while tx_busy is high
		tx_string = {$urandom, $urandom, $urandom, $urandom};
		pulse_req(4);
		wait_frames(tx_sent, rx_expect);
		idle_cycles(QUIET_CYCLES);

		$display("closing: %0d check errors, %0d timeouts", err_count, timeouts);
		if (err_count == 0 && timeouts == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: list.f
design/uart_string_pkg.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_string_handle.sv
testbench/tb_uart_string_checker.sv
testbench/tb_uart_string.sv

// File: Makefile
# Verilator build and run for the uart string link testbench

VERILATOR ?= verilator
TOP       ?= tb_uart_string
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
